// ==== vlog.f ====
hw/texBufferPkg.sv
hw/texBufferIfs.sv
hw/texelBank.sv
hw/streamWriter.sv
hw/quadAddrGen.sv
hw/quadSelect.sv
hw/textureBuffer.sv
tests/textureBuffer_props.sv
tests/textureBufferTb.sv

// ==== Bender.yml ====
package:
  name: texture_buffer

sources:
  - hw/texBufferPkg.sv
  - hw/texBufferIfs.sv
  - hw/texelBank.sv
  - hw/streamWriter.sv
  - hw/quadAddrGen.sv
  - hw/quadSelect.sv
  - hw/textureBuffer.sv
  - target: test
    files:
      - tests/textureBuffer_props.sv
      - tests/textureBufferTb.sv

// ==== tests/textureBufferTb.sv ====
// Texture buffer testbench
`timescale 1ns/10ps

module textureBufferTb;
    import texBufferPkg::*;

    localparam int SIZE_LOG2 = 14;
    localparam int TEXELS    = 2 ** (SIZE_LOG2 - 1);
    localparam int NUM_ROWS  = 15;

    typedef struct
    {
        int        testId;
        sizeCode_t width;
        sizeCode_t height;
        coord_t    s;
        coord_t    t;
        logic      clampS;
        logic      clampT;
        pixel_t    expQuad [4]; // 00, 01, 10, 11
        subCoord_t expS;
        subCoord_t expT;
    } readRow_t;

    logic          aclk;
    logic          resetn;
    logic          streamValid;
    logic          streamLast;
    logic [31 : 0] streamData;
    logic          streamReady;
    sizeCode_t     textureSizeWidth;
    sizeCode_t     textureSizeHeight;
    coord_t        texelS;
    coord_t        texelT;
    logic          clampS;
    logic          clampT;
    pixel_t        texel00, texel01, texel10, texel11;
    subCoord_t     texelSubCoordS, texelSubCoordT;

    pixel_t   texMem [TEXELS]; // Reference copy of the texture
    readRow_t rows [NUM_ROWS];
    int       errorCount = 0;
    int       checkCount = 0;
    int       testErrors = 0;
    logic     readyWatch = 1'b0;
    bit       readyOk;

    textureBuffer #(.SIZE_LOG2(SIZE_LOG2)) i_dut (
        .aclk(aclk), .resetn(resetn), .streamValid(streamValid), .streamLast(streamLast),
        .streamData(streamData), .streamReady(streamReady),
        .textureSizeWidth(textureSizeWidth), .textureSizeHeight(textureSizeHeight),
        .texelS(texelS), .texelT(texelT), .clampS(clampS), .clampT(clampT),
        .texel00(texel00), .texel01(texel01), .texel10(texel10), .texel11(texel11),
        .texelSubCoordS(texelSubCoordS), .texelSubCoordT(texelSubCoordT)
    );

    initial
    begin
        aclk = 1'b0;
        forever #5 aclk = ~aclk;
    end

    // Ready watch after reset
    always @(negedge aclk)
    begin
        if (readyWatch)
        begin
            checkCount++;
            if (streamReady !== 1'b1)
            begin
                reportMismatch("streamReady low after reset");
            end
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Reference model
    //////////////////////////////////////////////////////////////////////
    function automatic int axisBits(input sizeCode_t code);
        int k;
        k = 0;
        for (int i = 0; i < 8; i++)
        begin
            if (code == sizeCode_t'(1 << i))
            begin
                k = i + 1;
            end
        end
        return k;
    endfunction

    task automatic modelAxis(input coord_t c, input int k, input logic clamp,
                             output int idx0, output int idx1, output subCoord_t frac,
                             output logic hit);
        int sum;
        idx0 = 0;
        idx1 = 0;
        frac = '0;
        hit  = 1'b0; // 1 px axis never hits
        if (k > 0)
        begin
            sum  = int'(c) + (1 << (15 - k));
            idx0 = (int'(c) >> (15 - k)) % (1 << k);
            idx1 = (idx0 + 1) % (1 << k);
            frac = subCoord_t'(int'(c) << (k + 1));
            hit  = clamp && ((sum > 16'hFFFF) || (!c[15] && sum[15]));
        end
    endtask

    task automatic fillExpected(input int i);
        int        kS;
        int        s0, s1, t0, t1;
        subCoord_t fracS, fracT;
        logic      hitS, hitT;
        pixel_t    q [4];
        kS = axisBits(rows[i].width);
        modelAxis(rows[i].s, kS, rows[i].clampS, s0, s1, fracS, hitS);
        modelAxis(rows[i].t, axisBits(rows[i].height), rows[i].clampT, t0, t1, fracT, hitT);
        q[0] = texMem[((t0 << kS) | s0) % TEXELS];
        q[1] = hitS ? q[0] : texMem[((t0 << kS) | s1) % TEXELS];
        q[2] = hitT ? q[0] : texMem[((t1 << kS) | s0) % TEXELS];
        q[3] = hitS ? q[2] : (hitT ? q[1] : texMem[((t1 << kS) | s1) % TEXELS]);
        rows[i].expQuad = q;
        rows[i].expS    = fracS;
        rows[i].expT    = fracT;
    endtask

    task automatic setRow(input int i, input int id, input sizeCode_t w, input sizeCode_t h,
                          input coord_t s, input coord_t t, input logic cs, input logic ct);
        rows[i].testId = id;
        rows[i].width  = w;
        rows[i].height = h;
        rows[i].s      = s;
        rows[i].t      = t;
        rows[i].clampS = cs;
        rows[i].clampT = ct;
    endtask

    // 16x8 texture for tests 2 and 3 then 4x4 and 1 px after the reload
    task automatic buildTable();
        setRow(0, 2, 8'h08, 8'h04, 16'h1A34, 16'h2B00, 1'b0, 1'b0);
        setRow(1, 2, 8'h08, 8'h04, 16'h4400, 16'h0FFF, 1'b0, 1'b0);
        setRow(2, 2, 8'h08, 8'h04, 16'h7C10, 16'h3000, 1'b0, 1'b0); // Right edge
        setRow(3, 2, 8'h08, 8'h04, 16'h2000, 16'h7500, 1'b0, 1'b0); // Bottom edge
        setRow(4, 2, 8'h08, 8'h04, 16'h7FFF, 16'h7FFF, 1'b0, 1'b0);
        setRow(5, 2, 8'h08, 8'h04, 16'h8800, 16'h9000, 1'b0, 1'b0);
        setRow(6, 3, 8'h08, 8'h04, 16'h7C10, 16'h3000, 1'b1, 1'b0);
        setRow(7, 3, 8'h08, 8'h04, 16'h2000, 16'h7500, 1'b0, 1'b1);
        setRow(8, 3, 8'h08, 8'h04, 16'h7FFF, 16'h7FFF, 1'b1, 1'b1);
        setRow(9, 3, 8'h08, 8'h04, 16'h1A34, 16'h2B00, 1'b1, 1'b1); // Interior with no hit
        setRow(10, 3, 8'h08, 8'h04, 16'hFC00, 16'hF000, 1'b1, 1'b1); // 16 bit overflow
        setRow(11, 5, 8'h02, 8'h02, 16'h3000, 16'h5000, 1'b0, 1'b0);
        setRow(12, 5, 8'h02, 8'h02, 16'h6800, 16'h7F00, 1'b0, 1'b0);
        setRow(13, 5, 8'h02, 8'h02, 16'h6800, 16'h7F00, 1'b1, 1'b1);
        setRow(14, 5, 8'h00, 8'h03, 16'h4321, 16'h1234, 1'b1, 1'b1);
    endtask

    //////////////////////////////////////////////////////////////////////
    // Stimulus and checks
    //////////////////////////////////////////////////////////////////////
    task automatic reportMismatch(input string msg);
        errorCount++;
        testErrors++;
        $display("mismatch at %0t: %s", $time, msg);
    endtask

    task automatic reportTest(input int id, input string name);
        $display("Test %0d %s: %0d errors", id, name, testErrors);
        testErrors = 0;
    endtask

    task automatic finishRun();
        $display("Checks run %0d, errors %0d", checkCount, errorCount);
        if (errorCount == 0)
        begin
            $display("All checks passed");
        end
        else
        begin
            $display("Checks failed");
        end
        $finish;
    endtask

    task automatic waitCycles(input int n);
        for (int c = 0; c < n; c++)
        begin
            @(negedge aclk);
        end
    endtask

    task automatic waitReady(output bit ok);
        int n;
        n = 0;
        while (streamReady !== 1'b1 && n < 20)
        begin
            @(negedge aclk);
            n++;
        end
        ok = (streamReady === 1'b1);
        if (!ok)
        begin
            $display("Timed out waiting for streamReady after reset");
            errorCount++;
        end
    endtask

    // Two texels per word with the even column in the low half
    task automatic loadTexture(input int words, input bit randomData);
        logic [31 : 0] word;
        for (int n = 0; n < words; n++)
        begin
            if (randomData)
            begin
                word = $urandom();
            end
            else
            begin
                word = {pixel_t'(2 * n + 1) ^ 16'hA5A5, pixel_t'(2 * n) ^ 16'hA5A5};
            end
            texMem[2 * n]     = word[15 : 0];
            texMem[2 * n + 1] = word[31 : 16];
            if ($urandom_range(3) == 0)
            begin
                streamValid = 1'b0; // Idle gap
                @(negedge aclk);
            end
            streamValid = 1'b1;
            streamLast  = (n == words - 1);
            streamData  = word;
            @(negedge aclk);
        end
        streamValid = 1'b0;
        streamLast  = 1'b0;
    endtask

    task automatic driveRead(input int i);
        textureSizeWidth  = rows[i].width;
        textureSizeHeight = rows[i].height;
        texelS            = rows[i].s;
        texelT            = rows[i].t;
        clampS            = rows[i].clampS;
        clampT            = rows[i].clampT;
    endtask

    task automatic checkRead(input int i);
        pixel_t got [4];
        got = '{texel00, texel01, texel10, texel11};
        for (int q = 0; q < 4; q++)
        begin
            checkCount++;
            if (got[q] !== rows[i].expQuad[q])
            begin
                reportMismatch($sformatf("row %0d texel%0d%0d got %h expected %h",
                               i, q / 2, q % 2, got[q], rows[i].expQuad[q]));
            end
        end
        checkCount += 2;
        if (texelSubCoordS !== rows[i].expS)
        begin
            reportMismatch($sformatf("row %0d subCoordS got %h expected %h",
                           i, texelSubCoordS, rows[i].expS));
        end
        if (texelSubCoordT !== rows[i].expT)
        begin
            reportMismatch($sformatf("row %0d subCoordT got %h expected %h",
                           i, texelSubCoordT, rows[i].expT));
        end
    endtask

    // One read at a time with the result two cycles later
    task automatic runIsolated(input int id, input string name);
        for (int i = 0; i < NUM_ROWS; i++)
        begin
            if (rows[i].testId == id)
            begin
                fillExpected(i);
                driveRead(i);
                waitCycles(2);
                checkRead(i);
            end
        end
        reportTest(id, name);
    endtask

    task automatic runPipelined();
        int issued [$];
        for (int i = 0; i < NUM_ROWS; i++)
        begin
            if (rows[i].testId != 5)
            begin
                issued.push_back(i);
            end
        end
        for (int n = 0; n < issued.size() + 2; n++)
        begin
            if (n >= 2)
            begin
                checkRead(issued[n - 2]);
            end
            if (n < issued.size())
            begin
                driveRead(issued[n]);
            end
            @(negedge aclk);
        end
        reportTest(4, "pipelined reads");
    endtask

    initial
    begin
        void'($urandom(88181));
        resetn            = 1'b0;
        streamValid       = 1'b0;
        streamLast        = 1'b0;
        streamData        = '0;
        textureSizeWidth  = '0;
        textureSizeHeight = '0;
        texelS            = '0;
        texelT            = '0;
        clampS            = 1'b0;
        clampT            = 1'b0;
        buildTable();

        for (int c = 0; c < 4; c++)
        begin
            @(negedge aclk);
            checkCount++;
            if (streamReady !== 1'b0)
            begin
                reportMismatch("streamReady high during reset");
            end
        end
        resetn = 1'b1;
        @(negedge aclk);
        waitReady(readyOk);
        if (readyOk)
        begin
            readyWatch = 1'b1;
            reportTest(1, "reset and ready");

            loadTexture(64, 1'b0); // 16x8 texels
            runIsolated(2, "wrap reads");
            runIsolated(3, "clamp reads");
            runPipelined();

            loadTexture(8, 1'b1);  // Restarts at address 0
            runIsolated(5, "tlast restart");
        end
        finishRun();
    end

endmodule

// ==== tests/textureBuffer_props.sv ====
// Texture buffer stream assertions
`timescale 1ns/10ps

module textureBufferProps #(
    parameter int ADDR_WIDTH = 12
)
(
    input logic                      aclk,
    input logic                      resetn,
    input logic                      streamValid,
    input logic                      streamLast,
    input logic                      streamReady,
    input logic [ADDR_WIDTH - 1 : 0] writeAddr
);

    // Ready comes up one cycle after reset and stays up
    assert property (@(posedge aclk) disable iff (!resetn)
        $past(resetn) |-> streamReady)
        else $error("streamReady low after reset");

    assert property (@(posedge aclk) disable iff (!resetn)
        streamValid && streamReady && streamLast |=> writeAddr == '0)
        else $error("write address not back at zero after the last word");

    assert property (@(posedge aclk) disable iff (!resetn)
        !streamValid |=> $stable(writeAddr)) // No word, no move
        else $error("write address moved without a stream word");

endmodule

bind textureBuffer textureBufferProps #(.ADDR_WIDTH(SIZE_LOG2 - 2)) i_props (
    .aclk(aclk), .resetn(resetn), .streamValid(streamValid), .streamLast(streamLast),
    .streamReady(streamReady), .writeAddr(bankWrite.writeAddr)
);

// ==== hw/textureBuffer.sv ====
// Texture buffer top level
`timescale 1ns/10ps

module textureBuffer #(
    parameter int SIZE_LOG2 = 14 // Memory size in bytes, log2
)
(
    input  logic                    aclk,
    input  logic                    resetn,

    // Texture load
    input  logic                    streamValid,
    input  logic                    streamLast,
    input  logic [31 : 0]           streamData,
    output logic                    streamReady,

    // Texel quad read
    input  texBufferPkg::sizeCode_t textureSizeWidth,
    input  texBufferPkg::sizeCode_t textureSizeHeight,
    input  texBufferPkg::coord_t    texelS,
    input  texBufferPkg::coord_t    texelT,
    input  logic                    clampS,
    input  logic                    clampT,
    output texBufferPkg::pixel_t    texel00,
    output texBufferPkg::pixel_t    texel01,
    output texBufferPkg::pixel_t    texel10,
    output texBufferPkg::pixel_t    texel11,
    output texBufferPkg::subCoord_t texelSubCoordS,
    output texBufferPkg::subCoord_t texelSubCoordT
);
    import texBufferPkg::*;

    bankWriteIf #(.SIZE_LOG2(SIZE_LOG2)) bankWrite ();
    bankAddrIf  #(.SIZE_LOG2(SIZE_LOG2)) bankAddr ();
    quadMetaIf                           quadMeta ();

    pixel_t dataEven0;
    pixel_t dataEven1;
    pixel_t dataOdd0;
    pixel_t dataOdd1;

    streamWriter #(.SIZE_LOG2(SIZE_LOG2)) i_streamWriter (
        .aclk(aclk), .resetn(resetn), .streamValid(streamValid), .streamLast(streamLast),
        .streamData(streamData), .streamReady(streamReady), .wr(bankWrite.writer)
    );

    quadAddrGen #(.SIZE_LOG2(SIZE_LOG2)) i_quadAddrGen (
        .aclk(aclk), .textureSizeWidth(textureSizeWidth), .textureSizeHeight(textureSizeHeight),
        .texelS(texelS), .texelT(texelT), .clampS(clampS), .clampT(clampT),
        .addr(bankAddr.gen), .meta(quadMeta.gen)
    );

    texelBank #(.SIZE_LOG2(SIZE_LOG2), .isOdd(1'b0)) bankEven (
        .aclk(aclk), .wr(bankWrite.bank), .readAddr0(bankAddr.addrEven0),
        .readAddr1(bankAddr.addrEven1), .rowData0(dataEven0), .rowData1(dataEven1)
    );

    texelBank #(.SIZE_LOG2(SIZE_LOG2), .isOdd(1'b1)) bankOdd (
        .aclk(aclk), .wr(bankWrite.bank), .readAddr0(bankAddr.addrOdd0),
        .readAddr1(bankAddr.addrOdd1), .rowData0(dataOdd0), .rowData1(dataOdd1)
    );

    quadSelect i_quadSelect (
        .aclk(aclk), .meta(quadMeta.sel), .dataEven0(dataEven0), .dataOdd0(dataOdd0),
        .dataEven1(dataEven1), .dataOdd1(dataOdd1), .texel00(texel00), .texel01(texel01),
        .texel10(texel10), .texel11(texel11), .subCoordS(texelSubCoordS),
        .subCoordT(texelSubCoordT)
    );

endmodule

// ==== hw/quadSelect.sv ====
// Texel quad select and clamp
`timescale 1ns/10ps

module quadSelect
(
    input  logic                    aclk,
    quadMetaIf.sel                  meta,
    input  texBufferPkg::pixel_t    dataEven0,
    input  texBufferPkg::pixel_t    dataOdd0,
    input  texBufferPkg::pixel_t    dataEven1,
    input  texBufferPkg::pixel_t    dataOdd1,
    output texBufferPkg::pixel_t    texel00,
    output texBufferPkg::pixel_t    texel01,
    output texBufferPkg::pixel_t    texel10,
    output texBufferPkg::pixel_t    texel11,
    output texBufferPkg::subCoord_t subCoordS,
    output texBufferPkg::subCoord_t subCoordT
);
    import texBufferPkg::*;

    pixel_t sel00;
    pixel_t sel01;
    pixel_t sel10;
    pixel_t sel11;
    pixel_t clamp01;
    pixel_t clamp10;
    pixel_t clamp11;

    //////////////////////////////////////////////////////////////////////
    // Bank select
    //////////////////////////////////////////////////////////////////////
    assign sel00 = meta.par00 ? dataOdd0 : dataEven0;
    assign sel01 = meta.par01 ? dataOdd0 : dataEven0;
    assign sel10 = meta.par10 ? dataOdd1 : dataEven1;
    assign sel11 = meta.par11 ? dataOdd1 : dataEven1;

    //////////////////////////////////////////////////////////////////////
    // Edge clamp
    //////////////////////////////////////////////////////////////////////
    assign clamp01 = meta.clampSHit ? sel00 : sel01;
    assign clamp10 = meta.clampTHit ? sel00 : sel10;

    // Both hits collapse the quad onto texel00
    assign clamp11 = meta.clampSHit ? clamp10 :
                     meta.clampTHit ? sel01 : sel11;

    always_ff @(posedge aclk)
    begin
        texel00   <= sel00;
        texel01   <= clamp01;
        texel10   <= clamp10;
        texel11   <= clamp11;
        subCoordS <= meta.subS;
        subCoordT <= meta.subT;
    end

endmodule

// ==== hw/quadAddrGen.sv ====
// Texel quad address generation
`timescale 1ns/10ps

module quadAddrGen #(
    parameter int SIZE_LOG2 = 14
)
(
    input  logic                    aclk,
    input  texBufferPkg::sizeCode_t textureSizeWidth,
    input  texBufferPkg::sizeCode_t textureSizeHeight,
    input  texBufferPkg::coord_t    texelS,
    input  texBufferPkg::coord_t    texelT,
    input  logic                    clampS,
    input  logic                    clampT,
    bankAddrIf.gen                  addr,
    quadMetaIf.gen                  meta
);
    import texBufferPkg::*;

    localparam int BANK_ADDR_WIDTH = SIZE_LOG2 - 2;

    // Index bits of an axis, 0 for a 1 px axis
    function automatic logic [3 : 0] indexBits(input sizeCode_t code);
        logic [3 : 0] bits;
        bits = 4'd0;
        for (int i = 0; i < 8; i++)
        begin
            if (code == (sizeCode_t'(1) << i))
            begin
                bits = 4'(i + 1);
            end
        end
        return bits;
    endfunction

    // One texel step in Q1.15
    function automatic coord_t stepOf(input logic [3 : 0] k);
        return (k == 4'd0) ? coord_t'(0) : (coord_t'(16'h8000) >> k);
    endfunction

    // Field [15-k .. 14], bit 15 dropped
    function automatic logic [7 : 0] indexOf(input coord_t c, input logic [3 : 0] k);
        return (k == 4'd0) ? 8'h0 : 8'(({1'b0, c[14 : 0]}) >> (4'd15 - k));
    endfunction

    // Remaining bits, left-justified
    function automatic subCoord_t fracOf(input coord_t c, input logic [3 : 0] k);
        return (k == 4'd0) ? subCoord_t'(0) : subCoord_t'(c << (k + 4'd1));
    endfunction

    logic [3 : 0] bitsS;
    logic [3 : 0] bitsT;
    coord_t       texelS1;      // Neighbor coordinates
    coord_t       texelT1;
    logic [7 : 0] idxS0;
    logic [7 : 0] idxS1;
    logic [7 : 0] idxT0;
    logic [7 : 0] idxT1;
    texAddr_t     addr00;
    texAddr_t     addr01;
    texAddr_t     addr10;
    texAddr_t     addr11;

    assign bitsS   = indexBits(textureSizeWidth);
    assign bitsT   = indexBits(textureSizeHeight);
    assign texelS1 = texelS + stepOf(bitsS);
    assign texelT1 = texelT + stepOf(bitsT);

    assign idxS0 = indexOf(texelS, bitsS);
    assign idxS1 = indexOf(texelS1, bitsS); // Wraps mod width
    assign idxT0 = indexOf(texelT, bitsT);
    assign idxT1 = indexOf(texelT1, bitsT);

    assign addr00 = (texAddr_t'(idxT0) << bitsS) | texAddr_t'(idxS0);
    assign addr01 = (texAddr_t'(idxT0) << bitsS) | texAddr_t'(idxS1);
    assign addr10 = (texAddr_t'(idxT1) << bitsS) | texAddr_t'(idxS0);
    assign addr11 = (texAddr_t'(idxT1) << bitsS) | texAddr_t'(idxS1);

    // Address bit 0 picks the bank, the rest is the bank row
    assign addr.addrEven0 = addr00[0] ? addr01[1 +: BANK_ADDR_WIDTH] : addr00[1 +: BANK_ADDR_WIDTH];
    assign addr.addrOdd0  = addr00[0] ? addr00[1 +: BANK_ADDR_WIDTH] : addr01[1 +: BANK_ADDR_WIDTH];
    assign addr.addrEven1 = addr10[0] ? addr11[1 +: BANK_ADDR_WIDTH] : addr10[1 +: BANK_ADDR_WIDTH];
    assign addr.addrOdd1  = addr10[0] ? addr10[1 +: BANK_ADDR_WIDTH] : addr11[1 +: BANK_ADDR_WIDTH];

    always_ff @(posedge aclk)
    begin
        meta.par00 <= addr00[0];
        meta.par01 <= addr01[0];
        meta.par10 <= addr10[0];
        meta.par11 <= addr11[0];

        // A hit is an overflow of the 16 bits or a carry into the integer bit
        meta.clampSHit <= clampS && ((texelS > texelS1) || (!texelS[15] && texelS1[15]));
        meta.clampTHit <= clampT && ((texelT > texelT1) || (!texelT[15] && texelT1[15]));

        meta.subS <= fracOf(texelS, bitsS);
        meta.subT <= fracOf(texelT, bitsT);
    end

endmodule

// ==== hw/streamWriter.sv ====
// Texture load stream writer
`timescale 1ns/10ps

module streamWriter #(
    parameter int SIZE_LOG2 = 14
)
(
    input  logic                      aclk,
    input  logic                      resetn,
    input  logic                      streamValid,
    input  logic                      streamLast,
    input  texBufferPkg::streamWord_u streamData,
    output logic                      streamReady,
    bankWriteIf.writer                wr
);
    import texBufferPkg::*;

    localparam int BANK_ADDR_WIDTH = SIZE_LOG2 - 2;

    logic [BANK_ADDR_WIDTH - 1 : 0] writeAddr; // One word per bank row
    logic                           accept;

    assign accept = streamValid && streamReady;

    always_ff @(posedge aclk)
    begin
        if (!resetn)
        begin
            writeAddr   <= '0;
            streamReady <= 1'b0;
        end
        else
        begin
            streamReady <= 1'b1; // Never back-pressured
            if (accept)
            begin
                // Last word of a texture restarts at the base
                writeAddr <= streamLast ? '0 : writeAddr + 1'b1;
            end
        end
    end

    assign wr.writeEn   = accept;
    assign wr.writeAddr = writeAddr;
    assign wr.evenData  = streamData.texels.evenTexel;
    assign wr.oddData   = streamData.texels.oddTexel;

endmodule

// ==== hw/texelBank.sv ====
// Texel RAM bank
`timescale 1ns/10ps

module texelBank #(
    parameter int SIZE_LOG2 = 14,
    parameter bit isOdd = 1'b0,
    localparam int BANK_ADDR_WIDTH = SIZE_LOG2 - 2
)
(
    input  logic                           aclk,
    bankWriteIf.bank                       wr,
    input  logic [BANK_ADDR_WIDTH - 1 : 0] readAddr0,
    input  logic [BANK_ADDR_WIDTH - 1 : 0] readAddr1,
    output texBufferPkg::pixel_t           rowData0, // Row t
    output texBufferPkg::pixel_t           rowData1  // Row t + 1
);
    import texBufferPkg::*;

    pixel_t                         mem [2 ** BANK_ADDR_WIDTH];
    pixel_t                         writeData;
    logic [BANK_ADDR_WIDTH - 1 : 0] addrB;

    // Each bank keeps one half of the stream word
    assign writeData = isOdd ? wr.oddData : wr.evenData;

    // The load owns port B while a word is written
    assign addrB = wr.writeEn ? wr.writeAddr : readAddr1;

    // Port A, read only
    always_ff @(posedge aclk)
    begin
        rowData0 <= mem[readAddr0];
    end

    // Port B, read first
    always_ff @(posedge aclk)
    begin
        if (wr.writeEn)
        begin
            mem[addrB] <= writeData;
        end
        rowData1 <= mem[addrB];
    end

endmodule

// ==== hw/texBufferIfs.sv ====
// Texture buffer internal interfaces
`timescale 1ns/10ps

//////////////////////////////////////////////////////////////////////
// Write side shared by both banks
//////////////////////////////////////////////////////////////////////
interface bankWriteIf #(
    parameter int SIZE_LOG2 = 14
);
    import texBufferPkg::*;

    localparam int BANK_ADDR_WIDTH = SIZE_LOG2 - 2;

    logic                           writeEn;
    logic [BANK_ADDR_WIDTH - 1 : 0] writeAddr;
    pixel_t                         evenData;
    pixel_t                         oddData;

    modport writer (output writeEn, output writeAddr, output evenData, output oddData);
    modport bank   (input writeEn, input writeAddr, input evenData, input oddData);
endinterface

//////////////////////////////////////////////////////////////////////
// Read addresses of the quad, row 0 and row 1 per bank
//////////////////////////////////////////////////////////////////////
interface bankAddrIf #(
    parameter int SIZE_LOG2 = 14
);
    localparam int BANK_ADDR_WIDTH = SIZE_LOG2 - 2;

    logic [BANK_ADDR_WIDTH - 1 : 0] addrEven0;
    logic [BANK_ADDR_WIDTH - 1 : 0] addrOdd0;
    logic [BANK_ADDR_WIDTH - 1 : 0] addrEven1;
    logic [BANK_ADDR_WIDTH - 1 : 0] addrOdd1;

    modport gen      (output addrEven0, output addrOdd0, output addrEven1, output addrOdd1);
    modport evenBank (input addrEven0, input addrEven1);
    modport oddBank  (input addrOdd0, input addrOdd1);
endinterface

//////////////////////////////////////////////////////////////////////
// Stage 0 to stage 1 metadata
//////////////////////////////////////////////////////////////////////
interface quadMetaIf;
    import texBufferPkg::*;

    logic      par00; // Column parity per texel, 1 is odd bank
    logic      par01;
    logic      par10;
    logic      par11;
    logic      clampSHit;
    logic      clampTHit;
    subCoord_t subS;
    subCoord_t subT;

    modport gen (
        output par00, output par01, output par10, output par11,
        output clampSHit, output clampTHit, output subS, output subT
    );
    modport sel (
        input par00, input par01, input par10, input par11,
        input clampSHit, input clampTHit, input subS, input subT
    );
endinterface

// ==== hw/texBufferPkg.sv ====
// Texture buffer shared types

package texBufferPkg;

    localparam int PIXEL_WIDTH = 16;

    typedef logic [PIXEL_WIDTH - 1 : 0] pixel_t;

    // Q1.15, bit 15 is the integer part
    typedef logic [15 : 0] coord_t;

    // Q0.16 position inside the texel quad
    typedef logic [15 : 0] subCoord_t;

    // One-hot, 8'b00000001 is 2 px up to 8'b10000000 for 256 px
    typedef logic [7 : 0] sizeCode_t;

    // Linear texel address, {t index, s index}
    typedef logic [15 : 0] texAddr_t;

    // One stream word holds two horizontally neighbored texels
    typedef union packed
    {
        logic [31 : 0] raw;
        struct packed
        {
            pixel_t oddTexel;  // Column 2n + 1
            pixel_t evenTexel; // Column 2n
        } texels;
    } streamWord_u;

endpackage
